/* list.f */
common/sdramPkg.sv
common/cpuBusPkg.sv
hw/sdramCtrl/cpuBusPort.sv
hw/sdramCtrl/refreshScheduler.sv
hw/sdramCtrl/sdramSequencer.sv
hw/sdramCtrl/sdramCtrlTop.sv
bench/sdramModel.sv
bench/tbSdramCtrl.sv

/* Bender.yml */
package:
  name: sdram_ctrl

sources:
  # packages first, then the controller blocks
  - files:
      - common/sdramPkg.sv
      - common/cpuBusPkg.sv
      - hw/sdramCtrl/cpuBusPort.sv
      - hw/sdramCtrl/refreshScheduler.sv
      - hw/sdramCtrl/sdramSequencer.sv
      - hw/sdramCtrl/sdramCtrlTop.sv

  # testbench, top module tbSdramCtrl
  - target: test
    files:
      - bench/sdramModel.sv
      - bench/tbSdramCtrl.sv

/* bench/tbSdramCtrl.sv */
////////////////////////////////////////
// testbench for the SDRAM controller
// random 68000 bus cycles against a
// reference memory, plus init, refresh,
// address map and handshake monitors
////////////////////////////////////////

`timescale 1ns/1ps

module tbSdramCtrl;
	import sdramPkg::*;
	import cpuBusPkg::*;

	localparam int NumAccesses   = 200;
	localparam int AckLimit      = 50;   // cycles to wait for Dtack_L
	localparam int InitCycles    = 3 + PowerUpCycles + 2 + InitRefreshes * (RefreshNopCycles + 2)
		+ ModeNopCycles + 6;
	localparam int TimeoutCycles = InitCycles + NumAccesses * 30;

	// mode register fields from A12 down to A0
	// single write, CAS latency, sequential, burst length 1
	localparam logic [RowWidth-1:0] ExpectedMode =
		{3'b000, 1'b1, 2'b00, 3'(CasLatency), 1'b0, 3'b000};

	typedef enum int {phPowerUp, phPrecharge, phRefresh, phModeNop, phRunning} initPhase;

	logic                 Clock = 1'b0;
	logic                 Reset_L;
	logic [31:0]          Address;
	logic [DataWidth-1:0] DataIn;
	logic                 UDS_L, LDS_L, DramSelect_L, WE_L, AS_L;
	logic [DataWidth-1:0] DataOut;
	logic                 SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L;
	logic [RowWidth-1:0]  SDram_Addr;
	logic [BankWidth-1:0] SDram_BA;
	wire  [DataWidth-1:0] SDram_DQ;
	logic                 Dtack_L, ResetOut_L;
	logic [4:0]           pinCmd;

	int                   errorCount = 0;
	int                   modelErrors;
	int                   cycleCount = 0;
	int                   reads = 0, writes = 0, refreshCount = 0;
	logic [31:0]          lfsr = 32'd66141;
	logic [DataWidth-1:0] refMem [int];      // reference memory indexed by location
	initPhase             phase = phPowerUp;
	int                   powerUpSeen = 0, initRefreshSeen = 0;
	int                   lastRefreshCycle = 0;
	logic                 refWindow = 1'b0;    // inside precharge..last NOP of a refresh
	int                   refNopsLeft = 0;
	int                   dtackLate = 0;
	logic [31:0]          curAddr = '0;
	logic                 curWrite = 1'b0;
	logic                 cycleActive = 1'b0;
	logic                 accessIssued = 1'b0;

	sdramCtrlTop UUT (.*);

	sdramModel sdram (
		.Clock (Clock), .CKE (SDram_CKE_H), .CS_L (SDram_CS_L), .RAS_L (SDram_RAS_L),
		.CAS_L (SDram_CAS_L), .WE_L (SDram_WE_L), .Addr (SDram_Addr), .BA (SDram_BA),
		.DQ (SDram_DQ), .errorCount (modelErrors)
	);

	assign pinCmd = {SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L};

	always #5 Clock = ~Clock;

	always @(negedge Clock)
		cycleCount++;

	// right shifting Galois LFSR
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		lfsrNext = {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	task automatic takeBits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			value = {value[30:0], lfsr[0]};
			lfsr  = lfsrNext(lfsr);               // one step per bit
		end
	endtask

	task automatic printCounts;
		$display("errors %0d (bench %0d, model %0d), reads %0d, writes %0d, refreshes %0d",
			errorCount + modelErrors, errorCount, modelErrors, reads, writes, refreshCount);
	endtask

	////////////////////////////////////////
	// one 68000 bus cycle on one of 64 locations spread over all fields
	task automatic busCycle(input logic write, input logic [5:0] idx,
		input logic [DataWidth-1:0] data);
		logic [31:0]          addr;
		logic [DataWidth-1:0] expected;
		int                   waitCycles;
		addr = '0;
		addr[BankLsb +: BankWidth] = idx[1:0];
		addr[RowLsb +: RowWidth]   = {idx[3:2], 11'h0a5};
		addr[ColLsb +: ColWidth]   = {idx[5:4], 8'h3c};
		expected = refMem.exists(int'(idx)) ? refMem[int'(idx)] : '0;
		@(negedge Clock);
		Address      = addr;
		DataIn       = data;
		WE_L         = !write;
		AS_L         = 1'b0;
		DramSelect_L = 1'b0;
		UDS_L        = 1'b0;
		LDS_L        = 1'b0;
		curAddr      = addr;
		curWrite     = write;
		accessIssued = 1'b0;
		cycleActive  = 1'b1;
		waitCycles   = 0;
		while (Dtack_L !== 1'b0 && waitCycles < AckLimit)
		begin
			@(negedge Clock);
			waitCycles++;
		end
		if (Dtack_L !== 1'b0)
		begin
			$display("no Dtack_L within %0d cycles for address 0x%h", AckLimit, addr);
			errorCount++;
		end
		else if (write)
		begin
			refMem[int'(idx)] = data;
			writes++;
		end
		else
		begin
			if (DataOut !== expected)
			begin
				$display("** Error DataOut expected 0x%h actual 0x%h at address 0x%h",
					expected, DataOut, addr);
				errorCount++;
			end
			reads++;
		end
		@(negedge Clock);
		AS_L         = 1'b1;                   // strobes released
		DramSelect_L = 1'b1;
		UDS_L        = 1'b1;
		LDS_L        = 1'b1;
		WE_L         = 1'b1;
		cycleActive  = 1'b0;
		@(negedge Clock);
		if (Dtack_L !== 1'b1)
		begin
			$display("Dtack_L still low one cycle after the strobes were released");
			errorCount++;
		end
	endtask

	////////////////////////////////////////
	// command monitor for init order, refresh, address map and handshake
	always @(posedge Clock)
	begin
		if (Reset_L)
		begin
			if (phase != phRunning && phase != phModeNop && ResetOut_L !== 1'b0)
			begin
				$display("ResetOut_L high before the mode register set");
				errorCount++;
			end
			case (phase)
			phPowerUp:
				if (pinCmd == cmdPowerUp)
					powerUpSeen++;               // the first one is still the reset value
				else
				begin
					if (pinCmd != cmdNop || powerUpSeen != PowerUpCycles + 1)
					begin
						$display("power-up ended after %0d cycles without a NOP", powerUpSeen);
						errorCount++;
					end
					phase = phPrecharge;
				end
			phPrecharge:
				if (pinCmd == cmdPrecharge)
				begin
					if (!SDram_Addr[PrechargeBit])
					begin
						$display("** Error SDram_Addr 0x%h, A10 expected high", SDram_Addr);
						errorCount++;
					end
					phase = phRefresh;
				end
				else if (pinCmd != cmdNop)
				begin
					$display("init command 0x%h came before the precharge-all", pinCmd);
					errorCount++;
				end
			phRefresh:
				if (pinCmd == cmdAutoRefresh)
					initRefreshSeen++;
				else if (pinCmd == cmdModeSet)
				begin
					if (initRefreshSeen != InitRefreshes)
					begin
						$display("mode set after %0d init refreshes", initRefreshSeen);
						errorCount++;
					end
					if (SDram_Addr !== ExpectedMode)
					begin
						$display("** Error SDram_Addr expected 0x%h actual 0x%h",
							ExpectedMode, SDram_Addr);
						errorCount++;
					end
					phase = phModeNop;
				end
				else if (pinCmd != cmdNop)
				begin
					$display("unexpected command 0x%h among init refreshes", pinCmd);
					errorCount++;
				end
			phModeNop:
			begin
				if (pinCmd != cmdNop)
				begin
					$display("command 0x%h before init finished", pinCmd);
					errorCount++;
				end
				if (ResetOut_L === 1'b1)
				begin
					phase = phRunning;
					lastRefreshCycle = cycleCount;
				end
			end
			phRunning:
			begin
				if (cycleCount - lastRefreshCycle > RefreshInterval + 12)
				begin
					$display("no auto-refresh for %0d cycles", cycleCount - lastRefreshCycle);
					errorCount++;
					lastRefreshCycle = cycleCount;   // one report per missed slot
				end
				case (pinCmd)
				cmdPrecharge:
				begin
					if (refWindow || !SDram_Addr[PrechargeBit])
					begin
						$display("refresh precharge out of order or without A10");
						errorCount++;
					end
					refWindow   = 1'b1;
					refNopsLeft = 0;
				end
				cmdAutoRefresh:
				begin
					if (!refWindow)
					begin
						$display("auto-refresh without a precharge before it");
						errorCount++;
					end
					refWindow        = 1'b1;
					refNopsLeft      = RefreshNopCycles;
					lastRefreshCycle = cycleCount;
					refreshCount++;
				end
				cmdNop:
					if (refWindow && refNopsLeft > 0)
					begin
						refNopsLeft--;
						if (refNopsLeft == 0)
							refWindow = 1'b0;        // refresh sequence complete
					end
				cmdActivate, cmdRead, cmdWrite:
				begin
					if (refWindow || !cycleActive)
					begin
						$display("access command inside a refresh or with no bus cycle");
						errorCount++;
					end
					if (pinCmd == cmdActivate)
					begin
						if (SDram_BA !== curAddr[BankLsb +: BankWidth])
						begin
							$display("** Error SDram_BA expected 0x%h actual 0x%h",
								curAddr[BankLsb +: BankWidth], SDram_BA);
							errorCount++;
						end
						if (SDram_Addr !== curAddr[RowLsb +: RowWidth])
						begin
							$display("** Error SDram_Addr expected 0x%h actual 0x%h",
								curAddr[RowLsb +: RowWidth], SDram_Addr);
							errorCount++;
						end
					end
					else
					begin
						if ((pinCmd == cmdWrite) != curWrite)
						begin
							$display("column command direction does not match the bus cycle");
							errorCount++;
						end
						if (SDram_Addr[ColWidth-1:0] !== curAddr[ColLsb +: ColWidth]
							|| !SDram_Addr[PrechargeBit])
						begin
							$display("** Error SDram_Addr expected 0x%h with A10 actual 0x%h",
								curAddr[ColLsb +: ColWidth], SDram_Addr);
							errorCount++;
						end
						accessIssued = 1'b1;
					end
				end
				default:
				begin
					$display("unexpected command 0x%h after init", pinCmd);
					errorCount++;
				end
				endcase
				// handshake
				if (Dtack_L === 1'b0 && !accessIssued)
				begin
					$display("Dtack_L low before the access command was issued");
					errorCount++;
				end
				dtackLate = (Dtack_L === 1'b0 && AS_L) ? dtackLate + 1 : 0;
				if (dtackLate == 2)
				begin
					$display("Dtack_L held low after AS_L went high");
					errorCount++;
				end
			end
			endcase
		end
	end

	initial
	begin : watchdog
		wait (cycleCount >= TimeoutCycles);
		$display("run stopped at the cycle limit of %0d", TimeoutCycles);
		printCounts();
		$display("Regression failed");
		$finish;
	end

	////////////////////////////////////////
	// main stimulus
	initial
	begin : stimulus
		logic [31:0] gap, write, idx, data;
		int          waitCycles;
		Reset_L      = 1'b0;
		Address      = '0;
		DataIn       = '0;
		UDS_L        = 1'b1;
		LDS_L        = 1'b1;
		DramSelect_L = 1'b1;
		WE_L         = 1'b1;
		AS_L         = 1'b1;
		repeat (3) @(negedge Clock);
		Reset_L = 1'b1;
		waitCycles = 0;
		while (ResetOut_L !== 1'b1 && waitCycles < InitCycles)   // CPU held in reset
		begin
			@(negedge Clock);
			waitCycles++;
		end
		if (ResetOut_L !== 1'b1)
		begin
			$display("ResetOut_L never went high after init");
			errorCount++;
		end
		for (int n = 0; n < NumAccesses; n++)
		begin
			takeBits(2, gap);
			repeat (gap) @(negedge Clock);
			takeBits(1, write);
			takeBits(6, idx);
			takeBits(16, data);
			busCycle(write[0], idx[5:0], data[DataWidth-1:0]);
		end
		repeat (10) @(negedge Clock);
		if (phase != phRunning || refreshCount == 0)
		begin
			$display("init never completed or no periodic refresh was seen");
			errorCount++;
		end
		printCounts();
		if (errorCount + modelErrors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* bench/sdramModel.sv */
////////////////////////////////////////
// behavioural SDRAM for the testbench
// decodes commands, checks bank state,
// stores words and returns read data
////////////////////////////////////////

`timescale 1ns/1ps

module sdramModel (
	input  logic                                Clock,
	input  logic                                CKE,
	input  logic                                CS_L,
	input  logic                                RAS_L,
	input  logic                                CAS_L,
	input  logic                                WE_L,
	input  logic [sdramPkg::RowWidth-1:0]       Addr,
	input  logic [sdramPkg::BankWidth-1:0]      BA,
	inout  wire  [sdramPkg::DataWidth-1:0]      DQ,
	output int                                  errorCount
);
	import sdramPkg::*;

	logic [DataWidth-1:0] mem [logic [24:0]];     // {bank, row, column}
	logic [RowWidth-1:0]  openRow [4];
	logic [3:0]           rowOpen = '0;
	logic [CasLatency:0]  readPipe = '0;          // read data on its way out
	logic [DataWidth-1:0] dataPipe [CasLatency+1];
	logic                 dqEn = 1'b0;
	logic [DataWidth-1:0] dqOut = '0;
	logic [4:0]           cmd;
	logic [24:0]          key;

	assign cmd = {CKE, CS_L, RAS_L, CAS_L, WE_L};
	assign key = {BA, openRow[BA], Addr[ColWidth-1:0]};
	assign DQ  = dqEn ? dqOut : {DataWidth{1'bz}};

	initial errorCount = 0;

	always @(posedge Clock)
	begin
		for (int i = CasLatency; i > 0; i--)
		begin
			readPipe[i] = readPipe[i-1];
			dataPipe[i] = dataPipe[i-1];
		end
		readPipe[0] = 1'b0;
		case (cmd)
		cmdActivate:
		begin
			if (rowOpen[BA])
			begin
				$display("sdramModel: activate on bank %0d while a row is open", BA);
				errorCount++;
			end
			openRow[BA] = Addr;
			rowOpen[BA] = 1'b1;
		end
		cmdRead, cmdWrite:
		begin
			if (!rowOpen[BA])
			begin
				$display("sdramModel: column access to bank %0d with no open row", BA);
				errorCount++;
			end
			else if (cmd == cmdRead)
			begin
				readPipe[0] = 1'b1;
				dataPipe[0] = mem.exists(key) ? mem[key] : '0;   // unwritten reads as 0
			end
			else
			begin
				if ($isunknown(DQ))
				begin
					$display("sdramModel: write to bank %0d with DQ not driven", BA);
					errorCount++;
				end
				mem[key] = DQ;
			end
			if (Addr[PrechargeBit])
				rowOpen[BA] = 1'b0;                          // auto-precharge
		end
		cmdPrecharge:
			if (Addr[PrechargeBit])
				rowOpen = '0;
			else
				rowOpen[BA] = 1'b0;
		cmdAutoRefresh, cmdModeSet:
			if (rowOpen != '0)
			begin
				$display("sdramModel: refresh or mode set with a bank still open");
				errorCount++;
			end
		default: ;                                           // NOP, power-up
		endcase
	end

	// drive half a cycle early so data is settled at the capture edge
	always @(negedge Clock)
	begin
		dqEn  = readPipe[CasLatency-1];
		dqOut = dataPipe[CasLatency-1];
	end

endmodule

/* hw/sdramCtrl/sdramCtrlTop.sv */
////////////////////////////////////////
// SDRAM controller top
// 68000 async bus on one side, 32M x16
// SDRAM on the other; bus port and refresh
// scheduler feed one command sequencer
////////////////////////////////////////

`timescale 1ns/1ps

module sdramCtrlTop (
	input  logic                                Clock,
	input  logic                                Reset_L,
	input  logic [cpuBusPkg::AddrWidth-1:0]     Address,
	input  logic [sdramPkg::DataWidth-1:0]      DataIn,
	input  logic                                UDS_L,
	input  logic                                LDS_L,
	input  logic                                DramSelect_L,
	input  logic                                WE_L,
	input  logic                                AS_L,
	output logic [sdramPkg::DataWidth-1:0]      DataOut,
	output logic                                SDram_CKE_H,
	output logic                                SDram_CS_L,
	output logic                                SDram_RAS_L,
	output logic                                SDram_CAS_L,
	output logic                                SDram_WE_L,
	output logic [sdramPkg::RowWidth-1:0]       SDram_Addr,
	output logic [sdramPkg::BankWidth-1:0]      SDram_BA,
	inout  wire  [sdramPkg::DataWidth-1:0]      SDram_DQ,
	output logic                                Dtack_L,
	output logic                                ResetOut_L
);
	import sdramPkg::*;
	import cpuBusPkg::*;

	accessReq req;          // bus port -> sequencer
	accessRsp rsp;          // sequencer -> bus port
	sdramPins pins;         // registered command/address
	logic     refreshDue;
	logic     refreshAck;
	logic     initDone;

	cpuBusPort busPort (
		.Clock        (Clock),
		.Reset_L      (Reset_L),
		.Address      (Address),
		.DataIn       (DataIn),
		.UDS_L        (UDS_L),
		.LDS_L        (LDS_L),
		.DramSelect_L (DramSelect_L),
		.WE_L         (WE_L),
		.AS_L         (AS_L),
		.req          (req),
		.rsp          (rsp),
		.DataOut      (DataOut),
		.Dtack_L      (Dtack_L)
	);

	refreshScheduler refreshSched (
		.Clock      (Clock),
		.Reset_L    (Reset_L),
		.initDone   (initDone),
		.refreshAck (refreshAck),
		.refreshDue (refreshDue)
	);

	sdramSequencer sequencer (
		.Clock      (Clock),
		.Reset_L    (Reset_L),
		.req        (req),
		.rsp        (rsp),
		.refreshDue (refreshDue),
		.refreshAck (refreshAck),
		.initDone   (initDone),
		.pins       (pins),
		.SDram_DQ   (SDram_DQ),
		.ResetOut_L (ResetOut_L)
	);

	// command pattern onto the named pins
	assign {SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} = pins.cmd;
	assign SDram_Addr = pins.addr;
	assign SDram_BA   = pins.bank;

endmodule

/* hw/sdramCtrl/sdramSequencer.sv */
////////////////////////////////////////
// SDRAM command sequencer
// power-up init, periodic refresh and
// single word read/write with auto-
// precharge; registered pins, DQ drive
// and read capture
////////////////////////////////////////

`timescale 1ns/1ps

module sdramSequencer (
	input  logic                                Clock,
	input  logic                                Reset_L,
	input  cpuBusPkg::accessReq                 req,
	output cpuBusPkg::accessRsp                 rsp,
	input  logic                                refreshDue,
	output logic                                refreshAck,
	output logic                                initDone,
	output sdramPkg::sdramPins                  pins,
	inout  wire  [sdramPkg::DataWidth-1:0]      SDram_DQ,
	output logic                                ResetOut_L
);
	import sdramPkg::*;

	seqState                   state;
	logic [SeqCountWidth-1:0]  count;          // power-up, NOP and CAS waits
	logic [InitCountWidth-1:0] initRefCount;
	logic                      dqDrive;
	logic [DataWidth-1:0]      writeData;
	logic [DataWidth-1:0]      readData;
	logic                      readCapture;
	logic                      done;
	logic                      initReached;
	logic [RowWidth-1:0]       colAddr;        // column with A10 set

	always_comb
	begin
		colAddr = RowWidth'(req.column);
		colAddr[PrechargeBit] = 1'b1;           // auto-precharge
	end

	// DQ sampled CasLatency edges after the SDRAM takes the read
	assign readCapture = (state == stCasWait) && (count == '0);

	////////////////////////////////////////
	// main FSM, pins registered here
	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			state        <= stPowerUp;
			count        <= SeqCountWidth'(PowerUpCycles);
			initRefCount <= '0;
			pins         <= '{cmd: cmdPowerUp, addr: '0, bank: '0};
			dqDrive      <= 1'b0;
			done         <= 1'b0;
			refreshAck   <= 1'b0;
			initReached  <= 1'b0;
		end
		else
		begin
			pins       <= '{cmd: cmdNop, addr: '0, bank: '0};   // NOP by default
			dqDrive    <= 1'b0;
			done       <= 1'b0;
			refreshAck <= 1'b0;
			if (state == stIdle)
				initReached <= 1'b1;           // sticky from here on

			case (state)
			stPowerUp:
				if (count != '0)
				begin
					count    <= count - 1'b1;
					pins.cmd <= cmdPowerUp;
				end
				else
					state <= stInitPrecharge;  // first NOP goes out now
			stInitPrecharge:
			begin
				pins.cmd               <= cmdPrecharge;
				pins.addr[PrechargeBit] <= 1'b1;   // all banks
				state                  <= stInitNop;
			end
			stInitNop:
				state <= stInitRefresh;
			stInitRefresh:
			begin
				pins.cmd <= cmdAutoRefresh;
				count    <= SeqCountWidth'(RefreshNopCycles - 1);
				state    <= stInitRefreshNop;
			end
			stInitRefreshNop:
				if (count != '0)
					count <= count - 1'b1;
				else if (initRefCount == InitCountWidth'(InitRefreshes - 1))
					state <= stModeSet;
				else
				begin
					initRefCount <= initRefCount + 1'b1;
					state        <= stInitRefresh;
				end
			stModeSet:
			begin
				pins.cmd  <= cmdModeSet;
				pins.addr <= ModeWord;         // bank stays 0
				count     <= SeqCountWidth'(ModeNopCycles - 1);
				state     <= stModeNop;
			end
			stModeNop:
				if (count != '0)
					count <= count - 1'b1;
				else
					state <= stIdle;

			// refresh has priority, an access just keeps waiting
			stIdle:
				if (refreshDue)
				begin
					pins.cmd                <= cmdPrecharge;
					pins.addr[PrechargeBit] <= 1'b1;
					refreshAck              <= 1'b1;
					state                   <= stRefNop;
				end
				else if (req.valid)
				begin
					pins  <= '{cmd: cmdActivate, addr: req.row, bank: req.bank};
					state <= req.write ? stWrite : stRead;
				end
			stRefNop:
				state <= stRefRefresh;
			stRefRefresh:
			begin
				pins.cmd <= cmdAutoRefresh;
				count    <= SeqCountWidth'(RefreshNopCycles - 1);
				state    <= stRefWait;
			end
			stRefWait:
				if (count != '0)
					count <= count - 1'b1;
				else
					state <= stIdle;

			stRead:
			begin
				pins  <= '{cmd: cmdRead, addr: colAddr, bank: req.bank};
				count <= SeqCountWidth'(CasLatency);
				state <= stCasWait;
			end
			stCasWait:
				if (count != '0)
					count <= count - 1'b1;
				else
				begin
					done  <= 1'b1;             // with the captured word
					state <= stAccessNop;
				end
			stWrite:
			begin
				pins    <= '{cmd: cmdWrite, addr: colAddr, bank: req.bank};
				dqDrive <= 1'b1;               // data on DQ with the command
				done    <= 1'b1;
				state   <= stAccessNop;
			end
			stAccessNop:
				state <= stIdle;               // lets the bus port drop valid
			default:
				state <= stIdle;
			endcase
		end
	end

	// data path
	always_ff @(posedge Clock)
	begin
		if (state == stWrite)
			writeData <= req.writeData;
		if (readCapture)
			readData <= SDram_DQ;
	end

	assign SDram_DQ   = dqDrive ? writeData : {DataWidth{1'bz}};
	assign rsp        = '{done: done, readData: readData};
	assign initDone   = initReached;
	assign ResetOut_L = initReached;   // CPU held in reset until init ends

	// DQ stays released from the read command until its data is back
	noDriveOnRead: assert property (@(posedge Clock) disable iff (!Reset_L)
		(pins.cmd == cmdRead) |-> (!dqDrive) [*CasLatency + 1]);

endmodule

/* hw/sdramCtrl/refreshScheduler.sv */
////////////////////////////////////////
// refresh scheduler
// interval down-counter, raises a sticky
// refresh request every RefreshInterval
////////////////////////////////////////

`timescale 1ns/1ps

module refreshScheduler (
	input  logic Clock,
	input  logic Reset_L,
	input  logic initDone,
	input  logic refreshAck,
	output logic refreshDue
);
	import sdramPkg::*;

	logic [RefreshCountWidth-1:0] count;

	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			count      <= RefreshCountWidth'(RefreshInterval);
			refreshDue <= 1'b0;
		end
		else if (!initDone || refreshAck)    // held loaded during init
		begin
			count      <= RefreshCountWidth'(RefreshInterval);
			refreshDue <= 1'b0;
		end
		else if (count > RefreshCountWidth'(1))
			count <= count - 1'b1;
		else
		begin
			count      <= '0;
			refreshDue <= 1'b1;              // stays up until acknowledged
		end
	end

	// sequencer only acks a request that is actually pending
	ackOnDue: assert property (@(posedge Clock) disable iff (!Reset_L)
		refreshAck |-> refreshDue);

endmodule

/* hw/sdramCtrl/cpuBusPort.sv */
////////////////////////////////////////
// 68000 bus port
// turns one bus cycle into one access
// request, returns read data and holds
// Dtack_L low until the strobes go away
////////////////////////////////////////

`timescale 1ns/1ps

module cpuBusPort (
	input  logic                                Clock,
	input  logic                                Reset_L,
	input  logic [cpuBusPkg::AddrWidth-1:0]     Address,
	input  logic [sdramPkg::DataWidth-1:0]      DataIn,
	input  logic                                UDS_L,
	input  logic                                LDS_L,
	input  logic                                DramSelect_L,
	input  logic                                WE_L,
	input  logic                                AS_L,
	output cpuBusPkg::accessReq                 req,
	input  cpuBusPkg::accessRsp                 rsp,
	output logic [sdramPkg::DataWidth-1:0]      DataOut,
	output logic                                Dtack_L
);
	import sdramPkg::*;
	import cpuBusPkg::*;

	typedef enum logic [1:0] {busWait, busRequest, busAck} busState;

	busState              state;
	logic                 reqValid;
	logic                 isWrite;
	logic [BankWidth-1:0] bankHeld;
	logic [RowWidth-1:0]  rowHeld;
	logic [ColWidth-1:0]  colHeld;
	logic [DataWidth-1:0] dataHeld;
	logic                 strobeLow;    // either byte lane active
	logic                 cycleStart;

	assign strobeLow  = !UDS_L || !LDS_L;
	// on writes the strobes only come once DataIn is valid
	assign cycleStart = (state == busWait) && !AS_L && !DramSelect_L && strobeLow;

	////////////////////////////////////////
	// bus cycle control
	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			state    <= busWait;
			reqValid <= 1'b0;
			Dtack_L  <= 1'b1;
		end
		else
		begin
			case (state)
			busWait:
				if (cycleStart)
				begin
					reqValid <= 1'b1;       // valid one cycle after the request
					state    <= busRequest;
				end
			busRequest:
				if (rsp.done)
				begin
					reqValid <= 1'b0;
					Dtack_L  <= 1'b0;       // ack one cycle after done
					state    <= busAck;
				end
			busAck:
				if (!strobeLow)             // both strobes released
				begin
					Dtack_L <= 1'b1;
					state   <= busWait;
				end
			default:
				state <= busWait;
			endcase
		end
	end

	// address split and data holding
	always_ff @(posedge Clock)
	begin
		if (cycleStart)
		begin
			isWrite  <= !WE_L;
			bankHeld <= Address[BankLsb +: BankWidth];
			rowHeld  <= Address[RowLsb +: RowWidth];
			colHeld  <= Address[ColLsb +: ColWidth];
			dataHeld <= DataIn;
		end
		if ((state == busRequest) && rsp.done && !isWrite)
			DataOut <= rsp.readData;        // kept until the next read
	end

	assign req = '{valid: reqValid, write: isWrite, bank: bankHeld, row: rowHeld,
		column: colHeld, writeData: dataHeld};

	// request must not change or drop until the sequencer answers
	reqStable: assert property (@(posedge Clock) disable iff (!Reset_L)
		req.valid && !rsp.done |=> req.valid && $stable(req));

endmodule

/* common/cpuBusPkg.sv */
////////////////////////////////////////
// 68000 bus side definitions
// address split and the request/response
// carried between bus port and sequencer
////////////////////////////////////////

package cpuBusPkg;

	localparam int AddrWidth = 32;

	// where each SDRAM field sits in the CPU byte address
	localparam int BankLsb = 24;   // bank in bits 25:24
	localparam int RowLsb  = 11;   // row in bits 23:11
	localparam int ColLsb  = 1;    // column in bits 10:1, bit 0 is the byte lane

	// one word access, fields held while valid is high
	typedef struct packed {
		logic                                valid;
		logic                                write;
		logic [sdramPkg::BankWidth-1:0]      bank;
		logic [sdramPkg::RowWidth-1:0]       row;
		logic [sdramPkg::ColWidth-1:0]       column;
		logic [sdramPkg::DataWidth-1:0]      writeData;
	} accessReq;

	// done is a single cycle pulse
	typedef struct packed {
		logic                                done;
		logic [sdramPkg::DataWidth-1:0]      readData;   // valid with done on reads
	} accessRsp;

endpackage

/* common/sdramPkg.sv */
////////////////////////////////////////
// SDRAM definitions
// command pin patterns, sequencer states,
// geometry and timing of the 32M x16 part
////////////////////////////////////////

package sdramPkg;

	// geometry: 4 banks, 8192 rows, 1024 columns, x16
	localparam int RowWidth  = 13;
	localparam int ColWidth  = 10;
	localparam int BankWidth = 2;
	localparam int DataWidth = 16;

	// timing in controller clocks
	localparam int PowerUpCycles    = 8;   // shortened for simulation
	localparam int InitRefreshes    = 8;
	localparam int RefreshNopCycles = 3;   // NOPs after each auto-refresh
	localparam int ModeNopCycles    = 3;
	localparam int RefreshInterval  = 375;
	localparam int CasLatency       = 2;

	// counter widths
	localparam int SeqCountWidth     = $clog2(PowerUpCycles + 1);
	localparam int InitCountWidth    = $clog2(InitRefreshes);
	localparam int RefreshCountWidth = $clog2(RefreshInterval + 1);

	// mode register: single write (A9), CAS 2 (A6:4), sequential, burst 1
	localparam logic [RowWidth-1:0] ModeWord = 13'h0220;
	localparam int PrechargeBit = 10;   // A10

	// pin order CKE, CS, RAS, CAS, WE
	typedef enum logic [4:0] {
		cmdPowerUp     = 5'b00000,   // CKE and CS held low
		cmdNop         = 5'b10111,
		cmdActivate    = 5'b10011,
		cmdRead        = 5'b10101,   // A10 picks auto-precharge
		cmdWrite       = 5'b10100,   // same here
		cmdPrecharge   = 5'b10010,   // A10 high for all banks
		cmdAutoRefresh = 5'b10001,
		cmdModeSet     = 5'b10000
	} sdramCmd;

	typedef enum logic [4:0] {
		stPowerUp, stInitPrecharge, stInitNop, stInitRefresh, stInitRefreshNop,
		stModeSet, stModeNop, stIdle, stRefNop, stRefRefresh, stRefWait,
		stRead, stCasWait, stWrite, stAccessNop
	} seqState;

	// everything that goes out on the command/address pins
	typedef struct packed {
		sdramCmd               cmd;
		logic [RowWidth-1:0]   addr;
		logic [BankWidth-1:0]  bank;
	} sdramPins;

endpackage
